// ==== fp_misc_pkg.sv ====
/*
 * Shared types for the single-precision misc write-back path.
 * IEEE 754 binary32 operands only; every integer result is 32 bits.
 * is_nan covers both NaN kinds, so a quiet NaN is is_nan without is_snan.
 */
`default_nettype none

package fp_misc_pkg;

    ////////////////////////////////////////////////////////////////////////////
    // Widths
    localparam int FLEN     = 32;
    localparam int XLEN     = 32;
    localparam int EXP_W    = 8;
    localparam int FRAC_W   = 23;
    localparam int ID_W     = 3;
    localparam int EXP_BIAS = 127;

    typedef logic [FLEN-1:0]   flen_t;
    typedef logic [XLEN-1:0]   xlen_t;
    typedef logic [EXP_W-1:0]  exp_t;
    typedef logic [FRAC_W-1:0] frac_t;
    // Significand with hidden bit on top
    typedef logic [FRAC_W:0]   sig_t;
    typedef logic [ID_W-1:0]   id_t;
    // Rounding mode, or funct3 for compares
    typedef logic [2:0]        rm_t;
    // NV DZ OF UF NX, NV in the MSB
    typedef logic [4:0]        fflags_t;
    typedef logic [9:0]        class_mask_t;
    // One-hot select: F2I, FCMP, FCLASS
    typedef logic [2:0]        misc_sel_t;

    ////////////////////////////////////////////////////////////////////////////
    // Encodings
    localparam rm_t RM_RNE = 3'd0;
    localparam rm_t RM_RTZ = 3'd1;
    localparam rm_t RM_RDN = 3'd2;
    localparam rm_t RM_RUP = 3'd3;
    localparam rm_t RM_RMM = 3'd4;

    localparam rm_t CMP_LE = 3'd0;
    localparam rm_t CMP_LT = 3'd1;
    localparam rm_t CMP_EQ = 3'd2;

    localparam misc_sel_t OP_F2I    = 3'b100;
    localparam misc_sel_t OP_FCMP   = 3'b010;
    localparam misc_sel_t OP_FCLASS = 3'b001;

    localparam fflags_t FFLAG_NV = 5'b10000;
    localparam fflags_t FFLAG_NX = 5'b00001;

    ////////////////////////////////////////////////////////////////////////////
    // Structs
    typedef struct packed {
        misc_sel_t op;
        flen_t     rs1;
        flen_t     rs2;
        rm_t       rm;
        logic      is_signed;
        id_t       id;
    } misc_req_t;

    typedef struct packed {
        flen_t value;
        logic  hidden_bit;
        logic  is_zero;
        logic  is_subnormal;
        logic  is_inf;
        logic  is_nan;
        logic  is_snan;
    } fp_operand_t;

    typedef struct packed {
        logic        new_request;
        id_t         id;
        fp_operand_t op1;
        fp_operand_t op2;
        rm_t         rm;
        logic        is_signed;
    } unit_issue_t;

    typedef struct packed {
        logic    done;
        id_t     id;
        xlen_t   rd;
        fflags_t fflags;
    } unit_result_t;

endpackage

`default_nettype wire

// ==== fp_operand_decode.sv ====
/*
 * Combinational field split and special-case flags for both operands.
 * Subnormals keep a zero hidden bit; no normalization is done here.
 */
`timescale 1ns/1ps
`default_nettype none

module fp_operand_decode (
    input  fp_misc_pkg::flen_t       rs1,
    input  fp_misc_pkg::flen_t       rs2,
    output fp_misc_pkg::fp_operand_t op1,
    output fp_misc_pkg::fp_operand_t op2
);

    // One operand's worth of classification
    function automatic fp_misc_pkg::fp_operand_t decode_one(input fp_misc_pkg::flen_t v);
        fp_misc_pkg::exp_t        e;
        fp_misc_pkg::frac_t       f;
        logic                     exp_zero;
        logic                     exp_ones;
        logic                     frac_zero;
        fp_misc_pkg::fp_operand_t d;

        e = v[fp_misc_pkg::FLEN-2 -: fp_misc_pkg::EXP_W];
        f = v[fp_misc_pkg::FRAC_W-1:0];

        exp_zero  = ~|e;
        exp_ones  = &e;
        frac_zero = ~|f;

        d.value = v;
        // Implicit leading one for every nonzero exponent
        d.hidden_bit   = ~exp_zero;
        d.is_zero      = exp_zero & frac_zero;
        d.is_subnormal = exp_zero & ~frac_zero;
        d.is_inf       = exp_ones & frac_zero;
        // Any NaN
        d.is_nan       = exp_ones & ~frac_zero;
        // Quiet bit clear with a nonzero payload
        d.is_snan      = exp_ones & ~f[fp_misc_pkg::FRAC_W-1] & ~frac_zero;
        return d;
    endfunction

    ////////////////////////////////////////////////////////////////////////////
    // Both operands through the same decode
    always_comb begin
        op1 = decode_one(rs1);
        op2 = decode_one(rs2);
    end

endmodule

`default_nettype wire

// ==== fp_f2i.sv ====
/*
 * FCVT.W.S / FCVT.WU.S, two stages, held while advance is low.
 * Out-of-range and NaN inputs saturate with NV; other inexact results set NX.
 */
`timescale 1ns/1ps
`default_nettype none

module fp_f2i (
    input  wire                        clk,
    input  wire                        rst_n,
    input  wire                        advance,
    input  fp_misc_pkg::unit_issue_t   issue,
    output fp_misc_pkg::unit_result_t  wb
);

    typedef struct packed {
        logic                done;
        fp_misc_pkg::id_t    id;
        logic                sign;
        fp_misc_pkg::xlen_t  int_part;
        logic                guard;
        logic                sticky;
        logic                big;
        logic                nan;
        fp_misc_pkg::rm_t    rm;
        logic                is_signed;
    } f2i_s1_t;

    fp_misc_pkg::sig_t   sig;
    logic signed [9:0]   exp_unb;
    logic [63:0]         aligned;
    f2i_s1_t             s1_next;
    f2i_s1_t             s1;
    logic                inc;
    logic [32:0]         rounded;
    fp_misc_pkg::xlen_t  pos_max;
    logic                ovf;
    fp_misc_pkg::unit_result_t wb_next;

    ////////////////////////////////////////////////////////////////////////////
    // Stage 1: align to a 32.32 fixed point
    always_comb begin
        sig     = {issue.op1.hidden_bit, issue.op1.value[fp_misc_pkg::FRAC_W-1:0]};
        exp_unb = 10'(issue.op1.value[30:23]) - 10'(fp_misc_pkg::EXP_BIAS);
        // Hidden bit lands on bit 32 for a zero exponent
        aligned = {31'b0, sig, 9'b0} << exp_unb[4:0];

        s1_next.done      = issue.new_request;
        s1_next.id        = issue.id;
        s1_next.sign      = issue.op1.value[fp_misc_pkg::FLEN-1];
        s1_next.big       = exp_unb > 10'sd31;
        s1_next.nan       = issue.op1.is_nan;
        s1_next.rm        = issue.rm;
        s1_next.is_signed = issue.is_signed;

        if (!exp_unb[9]) begin
            s1_next.int_part = aligned[63:32];
            s1_next.guard    = aligned[31];
            s1_next.sticky   = |aligned[30:0];
        end else if (exp_unb == -10'sd1) begin
            // Value in [0.5, 1)
            s1_next.int_part = '0;
            s1_next.guard    = sig[fp_misc_pkg::FRAC_W];
            s1_next.sticky   = |sig[fp_misc_pkg::FRAC_W-1:0];
        end else begin
            // Below one half, only sticky survives
            s1_next.int_part = '0;
            s1_next.guard    = 1'b0;
            s1_next.sticky   = |sig;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            s1.done <= 1'b0;
        end else if (advance) begin
            s1 <= s1_next;
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // Stage 2: round the magnitude, then sign and saturate
    always_comb begin
        case (s1.rm)
            fp_misc_pkg::RM_RNE: inc = s1.guard & (s1.sticky | s1.int_part[0]);
            fp_misc_pkg::RM_RTZ: inc = 1'b0;
            fp_misc_pkg::RM_RDN: inc = s1.sign & (s1.guard | s1.sticky);
            fp_misc_pkg::RM_RUP: inc = ~s1.sign & (s1.guard | s1.sticky);
            fp_misc_pkg::RM_RMM: inc = s1.guard;
            default:             inc = 1'b0;
        endcase
        rounded = {1'b0, s1.int_part} + 33'(inc);

        pos_max = s1.is_signed ? 32'h7FFF_FFFF : 32'hFFFF_FFFF;
        // Largest magnitude allowed on each side
        if (s1.sign)
            ovf = s1.big | (rounded > (s1.is_signed ? 33'h0_8000_0000 : 33'h0));
        else
            ovf = s1.big | (rounded > {1'b0, pos_max});

        wb_next.done = s1.done;
        wb_next.id   = s1.id;
        if (s1.nan) begin
            wb_next.rd     = pos_max;
            wb_next.fflags = fp_misc_pkg::FFLAG_NV;
        end else if (ovf) begin
            // Unsigned minimum is zero
            wb_next.rd     = s1.sign ? (s1.is_signed ? 32'h8000_0000 : 32'h0) : pos_max;
            wb_next.fflags = fp_misc_pkg::FFLAG_NV;
        end else begin
            wb_next.rd     = s1.sign ? -rounded[31:0] : rounded[31:0];
            wb_next.fflags = (s1.guard | s1.sticky) ? fp_misc_pkg::FFLAG_NX : '0;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            wb.done <= 1'b0;
        end else if (advance) begin
            wb <= wb_next;
        end
    end

endmodule

`default_nettype wire

// ==== fp_cmp.sv ====
/*
 * FEQ / FLT / FLE, two stages, selected by funct3 carried in rm.
 * FEQ flags NV only for a signaling NaN; FLT and FLE flag any NaN.
 */
`timescale 1ns/1ps
`default_nettype none

module fp_cmp (
    input  wire                        clk,
    input  wire                        rst_n,
    input  wire                        advance,
    input  fp_misc_pkg::unit_issue_t   issue,
    output fp_misc_pkg::unit_result_t  wb
);

    typedef struct packed {
        logic             done;
        fp_misc_pkg::id_t id;
        fp_misc_pkg::rm_t rm;
        logic             lt;
        logic             eq;
        logic             any_nan;
        logic             any_snan;
    } cmp_s1_t;

    fp_misc_pkg::flen_t a;
    fp_misc_pkg::flen_t b;
    logic               both_zero;
    cmp_s1_t            s1_next;
    cmp_s1_t            s1;
    fp_misc_pkg::unit_result_t wb_next;

    ////////////////////////////////////////////////////////////////////////////
    // Stage 1: sign-magnitude ordering
    always_comb begin
        a = issue.op1.value;
        b = issue.op2.value;
        // +0 and -0 compare equal
        both_zero = issue.op1.is_zero & issue.op2.is_zero;

        s1_next.done     = issue.new_request;
        s1_next.id       = issue.id;
        s1_next.rm       = issue.rm;
        s1_next.eq       = (a == b) | both_zero;
        s1_next.any_nan  = issue.op1.is_nan | issue.op2.is_nan;
        s1_next.any_snan = issue.op1.is_snan | issue.op2.is_snan;

        if (a[31] != b[31])
            s1_next.lt = a[31] & ~both_zero;
        else if (!a[31])
            s1_next.lt = a[30:0] < b[30:0];
        else
            // Both negative, larger magnitude is smaller
            s1_next.lt = a[30:0] > b[30:0];
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            s1.done <= 1'b0;
        end else if (advance) begin
            s1 <= s1_next;
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // Stage 2: pick the relation, NaN forces zero
    always_comb begin
        wb_next.done   = s1.done;
        wb_next.id     = s1.id;
        wb_next.rd     = '0;
        wb_next.fflags = '0;
        case (s1.rm)
            fp_misc_pkg::CMP_EQ: begin
                wb_next.rd[0]  = ~s1.any_nan & s1.eq;
                wb_next.fflags = s1.any_snan ? fp_misc_pkg::FFLAG_NV : '0;
            end
            fp_misc_pkg::CMP_LT: begin
                wb_next.rd[0]  = ~s1.any_nan & s1.lt;
                wb_next.fflags = s1.any_nan ? fp_misc_pkg::FFLAG_NV : '0;
            end
            fp_misc_pkg::CMP_LE: begin
                wb_next.rd[0]  = ~s1.any_nan & (s1.lt | s1.eq);
                wb_next.fflags = s1.any_nan ? fp_misc_pkg::FFLAG_NV : '0;
            end
            default: ;
        endcase
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            wb.done <= 1'b0;
        end else if (advance) begin
            wb <= wb_next;
        end
    end

endmodule

`default_nettype wire

// ==== fp_class.sv ====
/*
 * FCLASS.S, mask built in stage 1 and registered again in stage 2.
 * Never raises flags.
 */
`timescale 1ns/1ps
`default_nettype none

module fp_class (
    input  wire                        clk,
    input  wire                        rst_n,
    input  wire                        advance,
    input  fp_misc_pkg::unit_issue_t   issue,
    output fp_misc_pkg::unit_result_t  wb
);

    typedef struct packed {
        logic                     done;
        fp_misc_pkg::id_t         id;
        fp_misc_pkg::class_mask_t mask;
    } class_s1_t;

    logic                     s;
    logic                     normal;
    fp_misc_pkg::fp_operand_t op;
    class_s1_t                s1_next;
    class_s1_t                s1;

    ////////////////////////////////////////////////////////////////////////////
    // Stage 1: one-hot class
    always_comb begin
        op     = issue.op1;
        s      = op.value[fp_misc_pkg::FLEN-1];
        normal = op.hidden_bit & ~op.is_inf & ~op.is_nan;

        s1_next.done    = issue.new_request;
        s1_next.id      = issue.id;
        s1_next.mask[0] = s & op.is_inf;
        s1_next.mask[1] = s & normal;
        s1_next.mask[2] = s & op.is_subnormal;
        s1_next.mask[3] = s & op.is_zero;
        s1_next.mask[4] = ~s & op.is_zero;
        s1_next.mask[5] = ~s & op.is_subnormal;
        s1_next.mask[6] = ~s & normal;
        s1_next.mask[7] = ~s & op.is_inf;
        // NaN sign is ignored
        s1_next.mask[8] = op.is_snan;
        s1_next.mask[9] = op.is_nan & ~op.is_snan;
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            s1.done <= 1'b0;
        end else if (advance) begin
            s1 <= s1_next;
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // Stage 2: zero-extend onto rd
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            wb.done <= 1'b0;
        end else if (advance) begin
            wb.done   <= s1.done;
            wb.id     <= s1.id;
            wb.rd     <= fp_misc_pkg::xlen_t'(s1.mask);
            wb.fflags <= '0;
        end
    end

endmodule

`default_nettype wire

// ==== fp_wb2int_misc.sv ====
/*
 * F2I, FCMP and FCLASS behind one integer write-back port.
 * One shared advance freezes every stage while a result waits for ack.
 * req.op must be one-hot when new_request is high.
 */
`timescale 1ns/1ps
`default_nettype none

module fp_wb2int_misc (
    input  wire                        clk,
    input  wire                        rst_n,
    input  wire                        new_request,
    input  fp_misc_pkg::misc_req_t     req,
    input  fp_misc_pkg::fp_operand_t   op1,
    input  fp_misc_pkg::fp_operand_t   op2,
    output logic                       ready,
    output fp_misc_pkg::unit_result_t  wb,
    input  wire                        wb_ack
);

    fp_misc_pkg::unit_issue_t  base_issue;
    fp_misc_pkg::unit_issue_t  f2i_issue;
    fp_misc_pkg::unit_issue_t  cmp_issue;
    fp_misc_pkg::unit_issue_t  class_issue;
    fp_misc_pkg::unit_result_t f2i_wb;
    fp_misc_pkg::unit_result_t cmp_wb;
    fp_misc_pkg::unit_result_t class_wb;
    fp_misc_pkg::misc_sel_t    op_s1;
    fp_misc_pkg::misc_sel_t    op_s2;
    logic                      advance;

    ////////////////////////////////////////////////////////////////////////////
    // Issue, same payload to all three units
    always_comb begin
        base_issue.new_request = 1'b0;
        base_issue.id          = req.id;
        base_issue.op1         = op1;
        base_issue.op2         = op2;
        base_issue.rm          = req.rm;
        base_issue.is_signed   = req.is_signed;

        f2i_issue   = base_issue;
        cmp_issue   = base_issue;
        class_issue = base_issue;
        // Only the selected unit sees the strobe
        f2i_issue.new_request   = new_request & req.op[2];
        cmp_issue.new_request   = new_request & req.op[1];
        class_issue.new_request = new_request & req.op[0];
    end

    fp_f2i i_fp_f2i (
        .clk     (clk),
        .rst_n   (rst_n),
        .advance (advance),
        .issue   (f2i_issue),
        .wb      (f2i_wb)
    );

    fp_cmp i_fp_cmp (
        .clk     (clk),
        .rst_n   (rst_n),
        .advance (advance),
        .issue   (cmp_issue),
        .wb      (cmp_wb)
    );

    fp_class i_fp_class (
        .clk     (clk),
        .rst_n   (rst_n),
        .advance (advance),
        .issue   (class_issue),
        .wb      (class_wb)
    );

    ////////////////////////////////////////////////////////////////////////////
    // Pipeline control
    // Move whenever the port is empty or being drained
    assign advance = wb_ack | ~wb.done;
    assign ready   = advance;

    // Select follows the data two stages deep
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            op_s1 <= '0;
            op_s2 <= '0;
        end else if (advance) begin
            op_s1 <= req.op;
            op_s2 <= op_s1;
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // Output mux
    always_comb begin
        case (op_s2)
            fp_misc_pkg::OP_F2I:  wb = f2i_wb;
            fp_misc_pkg::OP_FCMP: wb = cmp_wb;
            default:              wb = class_wb;
        endcase
    end

endmodule

`default_nettype wire

// ==== fp_misc_top.sv ====
/*
 * Operand decode in front of the misc write-back block.
 * req is sampled only on the accepting edge.
 */
`timescale 1ns/1ps
`default_nettype none

module fp_misc_top (
    input  wire                        clk,
    input  wire                        rst_n,
    input  wire                        new_request,
    input  fp_misc_pkg::misc_req_t     req,
    output logic                       ready,
    output fp_misc_pkg::unit_result_t  wb,
    input  wire                        wb_ack
);

    fp_misc_pkg::fp_operand_t op1;
    fp_misc_pkg::fp_operand_t op2;

    // Zero-cycle decode
    fp_operand_decode i_fp_operand_decode (
        .rs1 (req.rs1),
        .rs2 (req.rs2),
        .op1 (op1),
        .op2 (op2)
    );

    fp_wb2int_misc i_fp_wb2int_misc (
        .clk         (clk),
        .rst_n       (rst_n),
        .new_request (new_request),
        .req         (req),
        .op1         (op1),
        .op2         (op2),
        .ready       (ready),
        .wb          (wb),
        .wb_ack      (wb_ack)
    );

endmodule

`default_nettype wire

// ==== tb_fp_misc_top.sv ====
/*
 * Testbench for fp_misc_top. Vectors are issued from a table in a loop
 * under random wb_ack stalls, then a short pass with wb_ack held high
 * checks the two-edge latency. Expected rd and fflags are hand-derived.
 */
`timescale 1ns/1ps
`default_nettype none

module tb_fp_misc_top;

    localparam int RESET_CYCLES = 16;
    localparam int LAT_FIRST    = 23;
    localparam int LAT_VECS     = 8;

    // Short names for the vector table
    localparam fp_misc_pkg::misc_sel_t F2I = fp_misc_pkg::OP_F2I;
    localparam fp_misc_pkg::misc_sel_t CMP = fp_misc_pkg::OP_FCMP;
    localparam fp_misc_pkg::misc_sel_t CLS = fp_misc_pkg::OP_FCLASS;
    localparam fp_misc_pkg::rm_t RNE = fp_misc_pkg::RM_RNE;
    localparam fp_misc_pkg::rm_t RTZ = fp_misc_pkg::RM_RTZ;
    localparam fp_misc_pkg::rm_t RDN = fp_misc_pkg::RM_RDN;
    localparam fp_misc_pkg::rm_t RUP = fp_misc_pkg::RM_RUP;
    localparam fp_misc_pkg::rm_t RMM = fp_misc_pkg::RM_RMM;
    localparam fp_misc_pkg::rm_t FEQ = fp_misc_pkg::CMP_EQ;
    localparam fp_misc_pkg::rm_t FLT = fp_misc_pkg::CMP_LT;
    localparam fp_misc_pkg::rm_t FLE = fp_misc_pkg::CMP_LE;
    // NV DZ OF UF NX
    localparam fp_misc_pkg::fflags_t NV   = 5'b10000;
    localparam fp_misc_pkg::fflags_t NX   = 5'b00001;
    localparam fp_misc_pkg::fflags_t NONE = 5'b00000;
    // Common binary32 operands
    localparam fp_misc_pkg::flen_t POS_ZERO = 32'h0000_0000;
    localparam fp_misc_pkg::flen_t NEG_ZERO = 32'h8000_0000;
    localparam fp_misc_pkg::flen_t POS_ONE  = 32'h3F80_0000;
    localparam fp_misc_pkg::flen_t NEG_ONE  = 32'hBF80_0000;
    localparam fp_misc_pkg::flen_t POS_TWO  = 32'h4000_0000;
    localparam fp_misc_pkg::flen_t NEG_TWO  = 32'hC000_0000;
    localparam fp_misc_pkg::flen_t POS_INF  = 32'h7F80_0000;
    localparam fp_misc_pkg::flen_t NEG_INF  = 32'hFF80_0000;
    localparam fp_misc_pkg::flen_t QNAN     = 32'h7FC0_0000;
    localparam fp_misc_pkg::flen_t SNAN     = 32'h7F80_0001;

    typedef struct packed {
        fp_misc_pkg::misc_sel_t op;
        fp_misc_pkg::flen_t     rs1;
        fp_misc_pkg::flen_t     rs2;
        fp_misc_pkg::rm_t       rm;
        logic                   is_signed;
        fp_misc_pkg::xlen_t     rd;
        fp_misc_pkg::fflags_t   fflags;
    } vec_t;

    // One outstanding request with the oldest at the queue head
    typedef struct packed {
        int                   accept_cycle;
        fp_misc_pkg::id_t     id;
        fp_misc_pkg::xlen_t   rd;
        fp_misc_pkg::fflags_t fflags;
    } expect_t;

    logic                      clk;
    logic                      rst_n;
    logic                      new_request;
    fp_misc_pkg::misc_req_t    req;
    logic                      ready;
    fp_misc_pkg::unit_result_t wb;
    logic                      wb_ack;

    vec_t    vecs[$];
    expect_t pending[$];
    int      seed;
    int      cycle;
    bit      table_loaded;

    fp_misc_top i_fp_misc_top (
        .clk         (clk),
        .rst_n       (rst_n),
        .new_request (new_request),
        .req         (req),
        .ready       (ready),
        .wb          (wb),
        .wb_ack      (wb_ack)
    );

    // 4 ns clock
    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    ////////////////////////////////////////////////////////////////////////////
    // Reporting and checks
    task automatic report_fail(input string what);
        $display("%s", what);
        $display("*** FAILED ***");
        $fatal(1, "simulation stopped");
    endtask

    task automatic compare_value(input string name, input logic [31:0] got,
                                 input logic [31:0] want);
        assert (got === want)
            else report_fail($sformatf("FAILED t=%0t %s got 0x%0h expected 0x%0h",
                                       $time, name, got, want));
    endtask

    task automatic check_idle();
        compare_value("wb.done", 32'(wb.done), 32'd0);
        compare_value("ready", 32'(ready), 32'd1);
    endtask

    // Head of the queue must match the result being consumed
    task automatic check_result(input bit timed);
        expect_t e;
        assert (pending.size() != 0)
            else report_fail("DUT returned a result with no request outstanding");
        e = pending.pop_front();
        compare_value("wb.id", 32'(wb.id), 32'(e.id));
        compare_value("wb.rd", wb.rd, e.rd);
        compare_value("wb.fflags", 32'(wb.fflags), 32'(e.fflags));
        // Request driven at edge N, result visible after edge N+2
        if (timed)
            compare_value("wb.done latency", 32'(cycle - e.accept_cycle), 32'd2);
    endtask

    task automatic add_vec(input fp_misc_pkg::misc_sel_t op, input fp_misc_pkg::flen_t rs1,
                           input fp_misc_pkg::flen_t rs2, input fp_misc_pkg::rm_t rm,
                           input logic is_signed, input fp_misc_pkg::xlen_t rd,
                           input fp_misc_pkg::fflags_t fflags);
        vec_t v;
        v.op        = op;
        v.rs1       = rs1;
        v.rs2       = rs2;
        v.rm        = rm;
        v.is_signed = is_signed;
        v.rd        = rd;
        v.fflags    = fflags;
        vecs.push_back(v);
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // Vector table
    task automatic build_table();
        // F2I of 2.5 and -2.5 under every rounding mode
        add_vec(F2I, 32'h4020_0000, POS_ZERO, RNE, 1'b1, 32'h0000_0002, NX);
        add_vec(F2I, 32'hC020_0000, POS_ZERO, RNE, 1'b1, 32'hFFFF_FFFE, NX);
        add_vec(F2I, 32'h4020_0000, POS_ZERO, RMM, 1'b1, 32'h0000_0003, NX);
        add_vec(F2I, 32'hC020_0000, POS_ZERO, RMM, 1'b1, 32'hFFFF_FFFD, NX);
        add_vec(F2I, 32'h4020_0000, POS_ZERO, RTZ, 1'b1, 32'h0000_0002, NX);
        add_vec(F2I, 32'hC020_0000, POS_ZERO, RDN, 1'b1, 32'hFFFF_FFFD, NX);
        add_vec(F2I, 32'h4020_0000, POS_ZERO, RDN, 1'b1, 32'h0000_0002, NX);
        add_vec(F2I, 32'h4020_0000, POS_ZERO, RUP, 1'b1, 32'h0000_0003, NX);
        add_vec(F2I, 32'hC020_0000, POS_ZERO, RUP, 1'b1, 32'hFFFF_FFFE, NX);
        // 3.5 ties up to even, 0.5 ties down to even
        add_vec(F2I, 32'h4060_0000, POS_ZERO, RNE, 1'b1, 32'h0000_0004, NX);
        add_vec(F2I, 32'h3F00_0000, POS_ZERO, RNE, 1'b0, 32'h0000_0000, NX);
        add_vec(F2I, 32'h3F00_0000, POS_ZERO, RMM, 1'b0, 32'h0000_0001, NX);
        add_vec(F2I, 32'h3FC0_0000, POS_ZERO, RUP, 1'b0, 32'h0000_0002, NX);
        add_vec(F2I, 32'hBFC0_0000, POS_ZERO, RTZ, 1'b1, 32'hFFFF_FFFF, NX);
        // Exact values
        add_vec(F2I, POS_ONE,       POS_ZERO, RNE, 1'b1, 32'h0000_0001, NONE);
        add_vec(F2I, 32'hC2C8_0000, POS_ZERO, RTZ, 1'b1, 32'hFFFF_FF9C, NONE);
        add_vec(F2I, 32'h4F32_D05E, POS_ZERO, RNE, 1'b0, 32'hB2D0_5E00, NONE);
        add_vec(F2I, 32'hCF00_0000, POS_ZERO, RNE, 1'b1, 32'h8000_0000, NONE);
        add_vec(F2I, NEG_ZERO,      POS_ZERO, RNE, 1'b0, 32'h0000_0000, NONE);
        // 3e9 does not fit a signed word
        add_vec(F2I, 32'h4F32_D05E, POS_ZERO, RNE, 1'b1, 32'h7FFF_FFFF, NV);
        // Negative unsigned where -1.0 overflows and -0.3 rounds to zero
        add_vec(F2I, NEG_ONE,       POS_ZERO, RTZ, 1'b0, 32'h0000_0000, NV);
        add_vec(F2I, 32'hBE99_999A, POS_ZERO, RNE, 1'b0, 32'h0000_0000, NX);
        // NaN and infinity saturation
        add_vec(F2I, QNAN,          POS_ZERO, RNE, 1'b1, 32'h7FFF_FFFF, NV);
        add_vec(F2I, QNAN,          POS_ZERO, RTZ, 1'b0, 32'hFFFF_FFFF, NV);
        add_vec(F2I, POS_INF,       POS_ZERO, RNE, 1'b1, 32'h7FFF_FFFF, NV);
        add_vec(F2I, NEG_INF,       POS_ZERO, RNE, 1'b1, 32'h8000_0000, NV);
        add_vec(F2I, NEG_INF,       POS_ZERO, RNE, 1'b0, 32'h0000_0000, NV);
        // FCMP ordered and equal pairs
        add_vec(CMP, POS_ONE,  POS_TWO,  FLT, 1'b0, 32'd1, NONE);
        add_vec(CMP, POS_TWO,  POS_ONE,  FLT, 1'b0, 32'd0, NONE);
        add_vec(CMP, POS_ONE,  POS_ONE,  FLE, 1'b0, 32'd1, NONE);
        add_vec(CMP, POS_TWO,  POS_ONE,  FLE, 1'b0, 32'd0, NONE);
        add_vec(CMP, POS_ONE,  POS_ONE,  FEQ, 1'b0, 32'd1, NONE);
        add_vec(CMP, POS_ONE,  POS_TWO,  FEQ, 1'b0, 32'd0, NONE);
        add_vec(CMP, NEG_TWO,  NEG_ONE,  FLT, 1'b0, 32'd1, NONE);
        add_vec(CMP, NEG_ONE,  POS_ONE,  FLT, 1'b0, 32'd1, NONE);
        // Signed zeros are equal
        add_vec(CMP, POS_ZERO, NEG_ZERO, FEQ, 1'b0, 32'd1, NONE);
        add_vec(CMP, NEG_ZERO, POS_ZERO, FLT, 1'b0, 32'd0, NONE);
        add_vec(CMP, NEG_ZERO, POS_ZERO, FLE, 1'b0, 32'd1, NONE);
        // Quiet NaN is silent for FEQ only
        add_vec(CMP, QNAN,     POS_ONE,  FEQ, 1'b0, 32'd0, NONE);
        add_vec(CMP, SNAN,     POS_ONE,  FEQ, 1'b0, 32'd0, NV);
        add_vec(CMP, QNAN,     POS_ONE,  FLT, 1'b0, 32'd0, NV);
        add_vec(CMP, POS_ONE,  SNAN,     FLE, 1'b0, 32'd0, NV);
        // FCLASS with one vector per mask bit
        add_vec(CLS, NEG_INF,       POS_ZERO, RNE, 1'b0, 32'h001, NONE);
        add_vec(CLS, NEG_ONE,       POS_ZERO, RNE, 1'b0, 32'h002, NONE);
        add_vec(CLS, 32'h8000_0001, POS_ZERO, RNE, 1'b0, 32'h004, NONE);
        add_vec(CLS, NEG_ZERO,      POS_ZERO, RNE, 1'b0, 32'h008, NONE);
        add_vec(CLS, POS_ZERO,      POS_ZERO, RNE, 1'b0, 32'h010, NONE);
        add_vec(CLS, 32'h0000_0001, POS_ZERO, RNE, 1'b0, 32'h020, NONE);
        add_vec(CLS, POS_ONE,       POS_ZERO, RNE, 1'b0, 32'h040, NONE);
        add_vec(CLS, POS_INF,       POS_ZERO, RNE, 1'b0, 32'h080, NONE);
        add_vec(CLS, SNAN,          POS_ZERO, RNE, 1'b0, 32'h100, NONE);
        add_vec(CLS, QNAN,          POS_ZERO, RNE, 1'b0, 32'h200, NONE);
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // Issue loop sampling at negedge and driving at posedge
    task automatic run_vectors(input int first, input int last, input bit ack_high);
        int                        idx;
        bit                        accepted;
        bit                        stalled;
        fp_misc_pkg::unit_result_t held_wb;
        expect_t                   e;
        fp_misc_pkg::misc_req_t    r;

        idx     = first;
        stalled = 1'b0;
        held_wb = '0;
        while (idx < last || pending.size() != 0) begin
            @(negedge clk);
            // A held result must not move
            if (stalled)
                assert (wb == held_wb)
                    else report_fail($sformatf("FAILED t=%0t wb got 0x%0h expected 0x%0h",
                                               $time, wb, held_wb));
            stalled = wb.done & ~wb_ack;
            held_wb = wb;
            if (stalled)
                compare_value("ready", 32'(ready), 32'd0);
            if (ack_high)
                compare_value("ready", 32'(ready), 32'd1);
            if (wb.done && wb_ack)
                check_result(ack_high);
            accepted = new_request & ready;
            if (accepted) begin
                // Edge that put this request on the bus
                e.accept_cycle = cycle;
                e.id           = idx[fp_misc_pkg::ID_W-1:0];
                e.rd           = vecs[idx].rd;
                e.fflags       = vecs[idx].fflags;
                pending.push_back(e);
            end
            @(posedge clk);
            cycle = cycle + 1;
            if (accepted)
                idx = idx + 1;
            if (idx < last) begin
                r.op        = vecs[idx].op;
                r.rs1       = vecs[idx].rs1;
                r.rs2       = vecs[idx].rs2;
                r.rm        = vecs[idx].rm;
                r.is_signed = vecs[idx].is_signed;
                r.id        = idx[fp_misc_pkg::ID_W-1:0];
                new_request <= 1'b1;
                req         <= r;
            end else begin
                new_request <= 1'b0;
            end
            // About 70% ack in the random pass
            wb_ack <= ack_high | (({$random(seed)} % 10) < 7);
        end
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // Main sequence
    initial begin
        seed         = 78;
        cycle        = 0;
        table_loaded = 1'b0;
        rst_n       <= 1'b0;
        new_request <= 1'b0;
        req         <= '0;
        wb_ack      <= 1'b0;
        build_table();
        table_loaded = 1'b1;

        // Idle port through reset and right after it
        repeat (RESET_CYCLES - 1) begin
            @(negedge clk);
            check_idle();
        end
        @(posedge clk);
        rst_n <= 1'b1;
        @(negedge clk);
        check_idle();

        run_vectors(0, vecs.size(), 1'b0);
        // Crosses the F2I to FCMP boundary back to back
        run_vectors(LAT_FIRST, LAT_FIRST + LAT_VECS, 1'b1);

        $display("*** PASSED ***");
        $finish;
    end

    // 20 cycles per issued vector plus reset
    initial begin : watchdog
        int limit;
        wait (table_loaded);
        limit = RESET_CYCLES + 20 * (vecs.size() + LAT_VECS);
        repeat (limit) @(posedge clk);
        report_fail("Timeout: results stopped arriving from the DUT");
    end

endmodule

`default_nettype wire

// ==== filelist.f ====
fp_misc_pkg.sv
fp_operand_decode.sv
fp_f2i.sv
fp_cmp.sv
fp_class.sv
fp_wb2int_misc.sv
fp_misc_top.sv
tb_fp_misc_top.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build the testbench with Verilator and run it.
# The exit status of the simulation is the test result.
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert \
    --top-module tb_fp_misc_top \
    -f filelist.f \
    -o sim_tb

./obj_dir/sim_tb
